//--- src/bank_pkg.sv
// Shared lane, width and selector constants
// Row, word and layout setting typedefs
// Read sequencer state encoding

package bank_pkg;

	// ======================================
	// Geometry
	// ======================================
	// Banks per row, also lanes per row
	localparam int NBANK   = 4;
	localparam int LANE_BW = 2;
	// One rotate enable per omega stage
	localparam int ROT_BW  = 1;
	// Selector reaches row-address bits 0 to 15
	localparam int SEL_BW  = 4;
	localparam int DATA_BW = 8;

	// ======================================
	// Types
	// ======================================
	typedef logic [DATA_BW-1:0]        data_t;
	// Lane or bank 0 in the low word
	typedef logic [NBANK*DATA_BW-1:0]  row_vec_t;
	typedef logic [SEL_BW-1:0]         xor_sel_t;
	// Selector i drives butterfly stage i
	typedef logic [LANE_BW*SEL_BW-1:0] xor_cfg_t;
	typedef logic [ROT_BW-1:0]         rot_cfg_t;

	typedef enum logic [1:0] {IDLE, ISSUE, DRAIN} rd_state_t;

endpackage

//--- src/bank_write_swizzle.sv
// Write-side layout network
// Butterfly stages LSB first, then the omega rotation
// Maps a lane-ordered row to bank order

`timescale 1ns/1ps

module bank_write_swizzle #(
	parameter int ROW_BW = 4
) (
	input  logic [ROW_BW-1:0]         i_row,
	input  bank_pkg::xor_cfg_t        i_xor,
	input  bank_pkg::rot_cfg_t        i_rot,
	input  bank_pkg::row_vec_t        i_data,
	output bank_pkg::row_vec_t        o_data
);

	// ======================================
	// Local constants
	// ======================================
	localparam int NBANK     = bank_pkg::NBANK;
	localparam int BW        = bank_pkg::DATA_BW;
	localparam int NBF       = bank_pkg::LANE_BW;
	localparam int NROT      = bank_pkg::ROT_BW;
	localparam int ADDR_SPAN = 1 << bank_pkg::SEL_BW;
	localparam int BANK_MASK = NBANK - 1;

	// ======================================
	// Internal
	// ======================================
	// Row address padded out to the selector range
	logic [ADDR_SPAN-1:0] row_ext;
	// Stage 0 is the input, last stage is the bank order
	bank_pkg::data_t      stage [NBF+NROT+1][NBANK];
	logic [NBF-1:0]       flip;

	// Selectors past ROW_BW land on zero padding
	always_comb begin
		row_ext = '0;
		row_ext[ROW_BW-1:0] = i_row;
	end

	always_comb begin
		bank_pkg::xor_sel_t sel;
		for (int i = 0; i < NBF; i++) begin
			sel = i_xor[i*bank_pkg::SEL_BW +: bank_pkg::SEL_BW];
			// Lane bits never feed a selector, so one flag per stage
			flip[i] = row_ext[sel];
		end
	end

	always_comb begin
		for (int j = 0; j < NBANK; j++) begin
			stage[0][j] = i_data[j*BW +: BW];
		end
		// Butterfly, LSB stage first
		for (int i = 0; i < NBF; i++) begin
			for (int j = 0; j < NBANK; j++) begin
				stage[i+1][j] = flip[i] ? stage[i][j ^ (1 << i)] : stage[i][j];
			end
		end
		// Omega rotation, lane j pulls lane j + 2^i
		for (int i = 0; i < NROT; i++) begin
			for (int j = 0; j < NBANK; j++) begin
				stage[NBF+i+1][j] = i_rot[i] ?
					stage[NBF+i][(j + (1 << i)) & BANK_MASK] :
					stage[NBF+i][j];
			end
		end
		for (int j = 0; j < NBANK; j++) begin
			o_data[j*BW +: BW] = stage[NBF+NROT][j];
		end
	end

endmodule

//--- src/bank_read_unswizzle.sv
// Read-side inverse layout network
// Reverse rotation, then butterfly stages MSB first
// Registered lane-order output with a valid strobe

`timescale 1ns/1ps

module bank_read_unswizzle #(
	parameter int ROW_BW = 4
) (
	input  logic                      i_clk,
	input  logic                      i_reset,
	input  logic                      i_en,
	input  logic [ROW_BW-1:0]         i_row,
	input  bank_pkg::xor_cfg_t        i_xor,
	input  bank_pkg::rot_cfg_t        i_rot,
	input  bank_pkg::row_vec_t        i_data,
	output bank_pkg::row_vec_t        o_data,
	output logic                      o_valid
);

	// ======================================
	// Local constants
	// ======================================
	localparam int NBANK     = bank_pkg::NBANK;
	localparam int BW        = bank_pkg::DATA_BW;
	localparam int NBF       = bank_pkg::LANE_BW;
	localparam int NROT      = bank_pkg::ROT_BW;
	localparam int ADDR_SPAN = 1 << bank_pkg::SEL_BW;
	localparam int BANK_MASK = NBANK - 1;

	logic [ADDR_SPAN-1:0] row_ext;
	bank_pkg::data_t      stage [NBF+NROT+1][NBANK];
	logic [NBF-1:0]       flip;
	bank_pkg::row_vec_t   lane_row;

	always_comb begin
		row_ext = '0;
		row_ext[ROW_BW-1:0] = i_row;
	end

	always_comb begin
		bank_pkg::xor_sel_t sel;
		for (int i = 0; i < NBF; i++) begin
			sel = i_xor[i*bank_pkg::SEL_BW +: bank_pkg::SEL_BW];
			flip[i] = row_ext[sel];
		end
	end

	always_comb begin
		for (int j = 0; j < NBANK; j++) begin
			stage[0][j] = i_data[j*BW +: BW];
		end
		// Undo the rotations, highest stage first
		// Lane j pulls lane j - 2^i modulo the bank count
		for (int k = 0; k < NROT; k++) begin
			for (int j = 0; j < NBANK; j++) begin
				stage[k+1][j] = i_rot[NROT-1-k] ?
					stage[k][(j + NBANK - (1 << (NROT-1-k))) & BANK_MASK] :
					stage[k][j];
			end
		end
		// Each butterfly is its own inverse, run them MSB first
		for (int k = 0; k < NBF; k++) begin
			for (int j = 0; j < NBANK; j++) begin
				stage[NROT+k+1][j] = flip[NBF-1-k] ?
					stage[NROT+k][j ^ (1 << (NBF-1-k))] :
					stage[NROT+k][j];
			end
		end
		for (int j = 0; j < NBANK; j++) begin
			lane_row[j*BW +: BW] = stage[NROT+NBF][j];
		end
	end

	// Output stage, one valid per enabled row
	always_ff @(posedge i_clk) begin
		if (i_en) begin
			o_data <= lane_row;
		end
		if (i_reset) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_en;
		end
	end

endmodule

//--- src/bank_array.sv
// Four single-write, single-read word banks
// Shared row address across banks, registered read

`timescale 1ns/1ps

module bank_array #(
	parameter int ROW_BW = 4
) (
	input  logic                      i_clk,
	input  logic                      i_wr_en,
	input  logic [ROW_BW-1:0]         i_wr_row,
	input  bank_pkg::row_vec_t        i_wr_data,
	input  logic                      i_rd_en,
	input  logic [ROW_BW-1:0]         i_rd_row,
	output bank_pkg::row_vec_t        o_rd_data
);

	// ======================================
	// Local constants
	// ======================================
	localparam int NBANK = bank_pkg::NBANK;
	localparam int BW    = bank_pkg::DATA_BW;
	localparam int DEPTH = 1 << ROW_BW;

	// Read register per bank
	bank_pkg::data_t rd_q [NBANK];

	// ======================================
	// Banks
	// ======================================
	for (genvar b = 0; b < NBANK; b++) begin : g_bank
		bank_pkg::data_t mem [DEPTH];

		// Bank b takes word b of the swizzled row
		always_ff @(posedge i_clk) begin
			if (i_wr_en) begin
				mem[i_wr_row] <= i_wr_data[b*BW +: BW];
			end
		end

		// Read holds its value while idle
		always_ff @(posedge i_clk) begin
			if (i_rd_en) begin
				rd_q[b] <= mem[i_rd_row];
			end
		end

		assign o_rd_data[b*BW +: BW] = rd_q[b];
	end

endmodule

//--- src/row_counter.sv
// Block read address counter
// Wrapping row address plus remaining row count

`timescale 1ns/1ps

module row_counter #(
	parameter int ROW_BW = 4
) (
	input  logic              i_clk,
	input  logic              i_reset,
	input  logic              i_load,
	input  logic              i_step,
	input  logic [ROW_BW-1:0] i_base,
	input  logic [ROW_BW:0]   i_count,
	output logic [ROW_BW-1:0] o_row,
	output logic              o_last
);

	// Rows still to issue, including the current one
	logic [ROW_BW:0] remain_q;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_row    <= '0;
			remain_q <= '0;
		end else if (i_load) begin
			o_row    <= i_base;
			remain_q <= i_count;
		end else if (i_step) begin
			// Address wraps at the array depth
			o_row    <= o_row + 1'b1;
			remain_q <= remain_q - 1'b1;
		end
	end

	// Current row is the final one of the block
	assign o_last = (remain_q == {{ROW_BW{1'b0}}, 1'b1});

endmodule

//--- src/read_sequencer.sv
// Block read FSM
// Issues one row per cycle, then flushes the read pipeline
// Drives counter load and step, bank read issue and busy

`timescale 1ns/1ps

module read_sequencer #(
	parameter int ROW_BW = 4
) (
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_start,
	input  logic i_last,
	output logic o_load,
	output logic o_step,
	output logic o_issue,
	output logic o_busy
);

	// Cycles the pipeline needs after the last issue
	localparam int DRAIN_CYCLES = 2;

	bank_pkg::rd_state_t state_q;
	bank_pkg::rd_state_t state_d;
	logic                drain_q;
	logic                drain_done;

	// ======================================
	// Next state
	// ======================================
	assign drain_done = drain_q == 1'(DRAIN_CYCLES - 1);

	always_comb begin
		state_d = state_q;
		case (state_q)
			bank_pkg::IDLE:  if (i_start) state_d = bank_pkg::ISSUE;
			bank_pkg::ISSUE: if (i_last) state_d = bank_pkg::DRAIN;
			bank_pkg::DRAIN: if (drain_done) state_d = bank_pkg::IDLE;
			default:         state_d = bank_pkg::IDLE;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state_q <= bank_pkg::IDLE;
			drain_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// Flush counter only runs in DRAIN
			drain_q <= (state_q == bank_pkg::DRAIN) ? !drain_done : 1'b0;
		end
	end

	// ======================================
	// Outputs
	// ======================================
	// Start is only taken while idle
	assign o_load  = i_start && (state_q == bank_pkg::IDLE);
	// One row per cycle for the whole ISSUE state
	assign o_issue = state_q == bank_pkg::ISSUE;
	assign o_step  = o_issue;
	assign o_busy  = state_q != bank_pkg::IDLE;

endmodule

//--- src/bank_remap_top.sv
// Banked row memory with XOR-swizzled lane layout
// Write swizzle, bank array, block read control, read unswizzle

`timescale 1ns/1ps

module bank_remap_top #(
	parameter int ROW_BW = 4
) (
	input  logic                      i_clk,
	input  logic                      i_reset,
	// Write port
	input  logic                      i_wr_en,
	input  logic [ROW_BW-1:0]         i_wr_row,
	input  bank_pkg::row_vec_t        i_wr_data,
	input  bank_pkg::xor_cfg_t        i_wr_xor,
	input  bank_pkg::rot_cfg_t        i_wr_rot,
	// Block read port
	input  logic                      i_rd_start,
	input  logic [ROW_BW-1:0]         i_rd_row,
	input  logic [ROW_BW:0]           i_rd_count,
	input  bank_pkg::xor_cfg_t        i_rd_xor,
	input  bank_pkg::rot_cfg_t        i_rd_rot,
	output bank_pkg::row_vec_t        o_rd_data,
	output logic                      o_rd_valid,
	output logic                      o_rd_busy
);

	// ======================================
	// Internal
	// ======================================
	bank_pkg::row_vec_t  wr_bank_data;
	bank_pkg::row_vec_t  rd_bank_data;
	logic                ctr_load;
	logic                ctr_step;
	logic                ctr_last;
	logic [ROW_BW-1:0]   ctr_row;
	logic                issue;
	// Issue and row, one cycle late to meet the bank read data
	logic                issue_q;
	logic [ROW_BW-1:0]   row_q;

	// Write path
	bank_write_swizzle #(.ROW_BW(ROW_BW)) u_wr_swizzle (
		.i_row  (i_wr_row),
		.i_xor  (i_wr_xor),
		.i_rot  (i_wr_rot),
		.i_data (i_wr_data),
		.o_data (wr_bank_data)
	);

	bank_array #(.ROW_BW(ROW_BW)) u_banks (
		.i_clk     (i_clk),
		.i_wr_en   (i_wr_en),
		.i_wr_row  (i_wr_row),
		.i_wr_data (wr_bank_data),
		.i_rd_en   (issue),
		.i_rd_row  (ctr_row),
		.o_rd_data (rd_bank_data)
	);

	// Block read control
	read_sequencer #(.ROW_BW(ROW_BW)) u_rd_seq (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_start (i_rd_start),
		.i_last  (ctr_last),
		.o_load  (ctr_load),
		.o_step  (ctr_step),
		.o_issue (issue),
		.o_busy  (o_rd_busy)
	);

	row_counter #(.ROW_BW(ROW_BW)) u_row_ctr (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_load  (ctr_load),
		.i_step  (ctr_step),
		.i_base  (i_rd_row),
		.i_count (i_rd_count),
		.o_row   (ctr_row),
		.o_last  (ctr_last)
	);

	// Row address rides along with the bank read
	always_ff @(posedge i_clk) begin
		if (issue) begin
			row_q <= ctr_row;
		end
		if (i_reset) begin
			issue_q <= 1'b0;
		end else begin
			issue_q <= issue;
		end
	end

	// Read path
	bank_read_unswizzle #(.ROW_BW(ROW_BW)) u_rd_unswizzle (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_en    (issue_q),
		.i_row   (row_q),
		.i_xor   (i_rd_xor),
		.i_rot   (i_rd_rot),
		.i_data  (rd_bank_data),
		.o_data  (o_rd_data),
		.o_valid (o_rd_valid)
	);

endmodule

//--- dv/bank_remap_sva.sv
// Read port assertions for the banked row memory
// Quiet after reset, valid inside busy, start from idle raises busy

`timescale 1ns/1ps

module bank_remap_sva (
	input logic i_clk,
	input logic i_reset,
	input logic i_rd_start,
	input logic i_rd_valid,
	input logic i_rd_busy
);

	// ========================================
	// Properties
	// ========================================
	// Reset leaves the read port quiet
	a_reset_quiet: assert property (@(posedge i_clk)
		i_reset |=> !i_rd_valid && !i_rd_busy)
		else $error("read port active in the cycle after reset");

	// Data only comes out during a block
	a_valid_in_busy: assert property (@(posedge i_clk) disable iff (i_reset)
		i_rd_valid |-> i_rd_busy)
		else $error("read valid seen while the port is not busy");

	// A start taken from idle opens a block
	a_start_busy: assert property (@(posedge i_clk) disable iff (i_reset)
		i_rd_start && !i_rd_busy |=> i_rd_busy)
		else $error("start from idle did not raise busy");

endmodule

bind bank_remap_top bank_remap_sva u_sva (
	.i_clk      (i_clk),
	.i_reset    (i_reset),
	.i_rd_start (i_rd_start),
	.i_rd_valid (o_rd_valid),
	.i_rd_busy  (o_rd_busy)
);

//--- dv/tb_bank_remap.sv
// Directed testbench for the banked row memory
// Lane network reference model, compare tasks, block read checker
// Watchdog and closing summary

`timescale 1ns/1ps

module tb_bank_remap;

	// ========================================
	// Constants
	// ========================================
	localparam int ROW_BW     = 4;
	localparam int DEPTH      = 1 << ROW_BW;
	localparam int NBANK      = bank_pkg::NBANK;
	localparam int BW         = bank_pkg::DATA_BW;
	localparam int SEL_BW     = bank_pkg::SEL_BW;
	localparam int CLK_PERIOD = 100;
	// One full fill plus one full block read with slack
	localparam int TEST_CYCLES = DEPTH + (DEPTH + 8) + 8;
	localparam int RUN_CYCLES  = 10 + 6 * TEST_CYCLES + 50;
	// Selectors 8 and 12 sit past the row bits, so no swaps
	localparam bank_pkg::xor_cfg_t ID_XOR = 8'hC8;

	logic                     i_clk;
	logic                     i_reset;
	logic                     i_wr_en;
	logic [ROW_BW-1:0]        i_wr_row;
	bank_pkg::row_vec_t       i_wr_data;
	bank_pkg::xor_cfg_t       i_wr_xor;
	bank_pkg::rot_cfg_t       i_wr_rot;
	logic                     i_rd_start;
	logic [ROW_BW-1:0]        i_rd_row;
	logic [ROW_BW:0]          i_rd_count;
	bank_pkg::xor_cfg_t       i_rd_xor;
	bank_pkg::rot_cfg_t       i_rd_rot;
	bank_pkg::row_vec_t       o_rd_data;
	logic                     o_rd_valid;
	logic                     o_rd_busy;

	// Model state, lane order as written and bank order as stored
	bank_pkg::row_vec_t written [DEPTH];
	bank_pkg::row_vec_t phys [DEPTH];
	logic [31:0]        lcg_state;
	int                 errors;
	int                 pass_cnt;
	int                 fail_cnt;

	bank_remap_top #(.ROW_BW(ROW_BW)) dut (.*);

	initial begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	// ========================================
	// Reference model
	// ========================================
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Combined butterfly swap mask, bit i for stage i
	function automatic logic [1:0] flip_mask(logic [ROW_BW-1:0] row, bank_pkg::xor_cfg_t cfg);
		logic [1:0] m;
		int         sel;
		m = '0;
		for (int i = 0; i < bank_pkg::LANE_BW; i++) begin
			sel = int'(cfg[i*SEL_BW +: SEL_BW]);
			// Selector past the row width reads as zero
			if (sel < ROW_BW)
				m[i] = row[sel];
		end
		return m;
	endfunction

	// Bank j holds lane ((j + rot) mod 4) xor mask
	function automatic bank_pkg::row_vec_t model_swizzle(logic [ROW_BW-1:0] row,
		bank_pkg::xor_cfg_t cfg, bank_pkg::rot_cfg_t rot, bank_pkg::row_vec_t data);
		bank_pkg::row_vec_t res;
		int                 m;
		int                 src;
		m = int'(flip_mask(row, cfg));
		for (int j = 0; j < NBANK; j++) begin
			src = ((j + int'(rot[0])) % NBANK) ^ m;
			res[j*BW +: BW] = data[src*BW +: BW];
		end
		return res;
	endfunction

	// ========================================
	// Compare and bookkeeping
	// ========================================
	task automatic check_row(string name, bank_pkg::row_vec_t got, bank_pkg::row_vec_t exp);
		if (got !== exp) begin
			$display("error: %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("error: %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(string name, int err_before);
		if (errors == err_before) begin
			pass_cnt++;
			$display("test %s: pass", name);
		end else begin
			fail_cnt++;
			$display("test %s: fail with %0d errors", name, errors - err_before);
		end
	endtask

	// ========================================
	// Drivers
	// ========================================
	task automatic write_row(logic [ROW_BW-1:0] row, bank_pkg::row_vec_t data,
		bank_pkg::xor_cfg_t cfg, bank_pkg::rot_cfg_t rot);
		i_wr_en   = 1'b1;
		i_wr_row  = row;
		i_wr_data = data;
		i_wr_xor  = cfg;
		i_wr_rot  = rot;
		@(posedge i_clk);
		#1;
		i_wr_en = 1'b0;
		written[row] = data;
		phys[row]    = model_swizzle(row, cfg, rot, data);
	endtask

	// Whole array with random rows under one layout
	task automatic fill_rows(bank_pkg::xor_cfg_t cfg, bank_pkg::rot_cfg_t rot);
		for (int r = 0; r < DEPTH; r++)
			write_row(ROW_BW'(r), lcg_next(), cfg, rot);
	endtask

	// Block read with per-edge timing checks, n counts edges after start
	task automatic run_block(logic [ROW_BW-1:0] base, int count, bank_pkg::xor_cfg_t cfg,
		bank_pkg::rot_cfg_t rot, bit lane_order, int restart_at);
		int                 n;
		int                 got;
		int                 idx;
		bit                 done;
		bank_pkg::row_vec_t exp;
		n    = 0;
		got  = 0;
		done = 1'b0;
		i_rd_xor   = cfg;
		i_rd_rot   = rot;
		i_rd_row   = base;
		i_rd_count = (ROW_BW+1)'(count);
		i_rd_start = 1'b1;
		@(posedge i_clk);
		#1;
		i_rd_start = 1'b0;
		while (!done) begin
			// Valid from the third edge, busy drops with the last valid
			check_bit("o_rd_busy", o_rd_busy, n <= count + 1);
			check_bit("o_rd_valid", o_rd_valid, n >= 2 && n <= count + 1);
			if (o_rd_valid === 1'b1) begin
				if (got < count) begin
					idx = (int'(base) + got) % DEPTH;
					exp = lane_order ? written[idx] : phys[idx];
					check_row("o_rd_data", o_rd_data, exp);
				end
				got++;
			end
			// Extra start while busy, different row and count
			i_rd_start = (n == restart_at);
			if (n == restart_at) begin
				i_rd_row   = base + 4'd5;
				i_rd_count = 5'd2;
			end
			if (n > 0 && o_rd_busy !== 1'b1) begin
				done = 1'b1;
			end else if (n > count + 8) begin
				$display("read block from row %0d did not finish in time", base);
				errors++;
				done = 1'b1;
			end else begin
				@(posedge i_clk);
				#1;
				n++;
			end
		end
		i_rd_start = 1'b0;
		if (got != count) begin
			$display("read block from row %0d gave %0d rows instead of %0d", base, got, count);
			errors++;
		end
	endtask

	// ========================================
	// Tests
	// ========================================
	task automatic test_identity_round_trip();
		int e0;
		e0 = errors;
		fill_rows(ID_XOR, 1'b0);
		run_block('0, DEPTH, ID_XOR, 1'b0, 1'b1, -1);
		end_test("identity round trip", e0);
	endtask

	// Selectors on row bits 0 and 1, read back raw
	task automatic test_butterfly_placement();
		int e0;
		e0 = errors;
		fill_rows(8'h10, 1'b0);
		run_block('0, DEPTH, ID_XOR, 1'b0, 1'b0, -1);
		end_test("butterfly placement", e0);
	endtask

	task automatic test_rotate_placement();
		int e0;
		e0 = errors;
		fill_rows(8'h32, 1'b1);
		run_block('0, DEPTH, ID_XOR, 1'b0, 1'b0, -1);
		end_test("rotation placement", e0);
	endtask

	// Stage 0 on row bit 3, stage 1 on row bit 0, rotate on
	task automatic test_matched_round_trip();
		int e0;
		e0 = errors;
		fill_rows(8'h03, 1'b1);
		run_block('0, DEPTH, 8'h03, 1'b1, 1'b1, -1);
		end_test("matched round trip", e0);
	endtask

	// Rows 14, 15, 0, 1, 2 from the previous fill
	task automatic test_block_wrap();
		int e0;
		e0 = errors;
		run_block(4'd14, 5, 8'h03, 1'b1, 1'b1, -1);
		end_test("block timing and wrap", e0);
	endtask

	task automatic test_start_while_busy();
		int e0;
		e0 = errors;
		run_block(4'd3, 6, 8'h03, 1'b1, 1'b1, 2);
		// Nothing may trail the block
		repeat (4) begin
			@(posedge i_clk);
			#1;
			check_bit("o_rd_valid", o_rd_valid, 1'b0);
			check_bit("o_rd_busy", o_rd_busy, 1'b0);
		end
		end_test("start ignored while busy", e0);
	endtask

	// ========================================
	// Main sequence and watchdog
	// ========================================
	initial begin
		lcg_state  = 32'hd17f72e3;
		errors     = 0;
		pass_cnt   = 0;
		fail_cnt   = 0;
		i_reset    = 1'b1;
		i_wr_en    = 1'b0;
		i_wr_row   = '0;
		i_wr_data  = '0;
		i_wr_xor   = '0;
		i_wr_rot   = '0;
		i_rd_start = 1'b0;
		i_rd_row   = '0;
		i_rd_count = '0;
		i_rd_xor   = '0;
		i_rd_rot   = '0;
		repeat (10) @(posedge i_clk);
		#1;
		i_reset = 1'b0;
		test_identity_round_trip();
		test_butterfly_placement();
		test_rotate_placement();
		test_matched_round_trip();
		test_block_wrap();
		test_start_while_busy();
		$display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
		if (errors == 0 && fail_cnt == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial begin
		#(RUN_CYCLES * CLK_PERIOD);
		$display("timeout after %0d cycles, the run did not complete", RUN_CYCLES);
		$display("tests failed");
		$finish;
	end

endmodule

//--- verilog.f
src/bank_pkg.sv
src/bank_write_swizzle.sv
src/bank_read_unswizzle.sv
src/bank_array.sv
src/row_counter.sv
src/read_sequencer.sv
src/bank_remap_top.sv
dv/bank_remap_sva.sv
dv/tb_bank_remap.sv

//--- run.sh
#!/bin/sh
# Build and run the banked row memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
EXE=sim_tb_bank_remap

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_bank_remap -f verilog.f -o "$EXE"
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/"$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "tests failed" "$LOG"; then
	exit 1
fi
exit 0
